/* source/gf_pkg.sv */
package gf_pkg;

	// GF(2^8), field polynomial x^8+x^4+x^3+x^2+1
	localparam int gf_m = 8;
	localparam logic [gf_m-1:0] gf_poly = 8'h1d;

	typedef logic [gf_m-1:0] gf_elem_t;

	// must count 0 to gf_m inclusive
	typedef logic [$clog2(gf_m+1)-1:0] gf_step_t;

	typedef enum logic [2:0] {
		op_mul,
		op_mul_serial,
		op_square,
		op_cube,
		op_inverse,
		op_alpha_pow
	} gf_op_t;

	// multiply by alpha: shift left, fold the carried x^8 back in
	function automatic gf_elem_t gf_xtime(gf_elem_t v);
		return {v[gf_m-2:0], 1'b0} ^ ({gf_m{v[gf_m-1]}} & gf_poly);
	endfunction

endpackage

/* source/gf_parallel_mult.sv */
module gf_parallel_mult import gf_pkg::*; (
	input gf_elem_t a,
	input gf_elem_t b,
	output gf_elem_t product
);

	// shift-and-add over the bits of b, least significant first
	always_comb begin : mult
		gf_elem_t acc;
		gf_elem_t shifted;
		acc = '0;
		shifted = a;
		for (int i = 0; i < gf_m; i++) begin
			if (b[i]) begin
				acc = acc ^ shifted;
			end
			// shifted holds a * alpha^(i+1) for the next bit
			shifted = gf_xtime(shifted);
		end
		product = acc;
	end

endmodule

/* source/gf_square_cube.sv */
module gf_square_cube import gf_pkg::*; (
	input gf_elem_t a,
	output gf_elem_t square,
	output gf_elem_t cube
);

	// gf_m diagonal terms a_i, then the cross terms a_i & a_j for i < j
	localparam int n_terms = gf_m * (gf_m + 1) / 2;

	function automatic gf_elem_t alpha_pow(int e);
		gf_elem_t p;
		p = gf_elem_t'(1);
		for (int i = 0; i < e; i++) begin
			p = gf_xtime(p);
		end
		return p;
	endfunction

	// bit i set when a_i contributes alpha^(2i) to output bit bit_pos
	function automatic gf_elem_t sq_mask(int bit_pos);
		gf_elem_t mask;
		gf_elem_t p;
		mask = '0;
		for (int i = 0; i < gf_m; i++) begin
			p = alpha_pow(2 * i);
			mask[i] = p[bit_pos];
		end
		return mask;
	endfunction

	function automatic logic [n_terms-1:0] cube_mask(int bit_pos);
		logic [n_terms-1:0] mask;
		gf_elem_t p;
		int k;
		mask = '0;
		for (int i = 0; i < gf_m; i++) begin
			p = alpha_pow(3 * i);
			mask[i] = p[bit_pos];
		end
		k = gf_m;
		for (int i = 0; i < gf_m - 1; i++) begin
			for (int j = i + 1; j < gf_m; j++) begin
				// a_i a_j appears as both x^(2i+j) and x^(2j+i)
				p = alpha_pow(2 * i + j) ^ alpha_pow(2 * j + i);
				mask[k] = p[bit_pos];
				k = k + 1;
			end
		end
		return mask;
	endfunction

	logic [n_terms-1:0] terms;

	always_comb begin : term_build
		int k;
		terms[gf_m-1:0] = a;
		k = gf_m;
		for (int i = 0; i < gf_m - 1; i++) begin
			for (int j = i + 1; j < gf_m; j++) begin
				terms[k] = a[i] & a[j];
				k = k + 1;
			end
		end
	end

	for (genvar n = 0; n < gf_m; n++) begin : gen_bit
		localparam gf_elem_t sq_mask_n = sq_mask(n);
		localparam logic [n_terms-1:0] cube_mask_n = cube_mask(n);
		assign square[n] = ^(a & sq_mask_n);
		assign cube[n] = ^(terms & cube_mask_n);
	end

endmodule

/* source/gf_serial_mult.sv */
module gf_serial_mult import gf_pkg::*; (
	input clk,
	input reset,
	input load,
	input gf_elem_t a,
	input gf_elem_t b,
	output gf_elem_t product,
	output logic finished
);

	gf_elem_t a_q;
	gf_elem_t b_q;
	gf_elem_t acc;
	gf_step_t step;
	logic running;

	always_ff @(posedge clk) begin
		if (reset) begin
			step <= '0;
			running <= 1'b0;
			finished <= 1'b0;
		end else begin
			finished <= 1'b0;
			if (load) begin
				step <= '0;
				running <= 1'b1;
			end else if (running) begin
				step <= step + 1'b1;
				if (step == gf_m - 1) begin
					running <= 1'b0;
					finished <= 1'b1;
				end
			end
		end
	end

	// horner form, b taken msb first
	always_ff @(posedge clk) begin
		if (load) begin
			acc <= '0;
			a_q <= a;
			b_q <= b;
		end else if (running) begin
			acc <= gf_xtime(acc) ^ (b_q[gf_m-1] ? a_q : '0);
			b_q <= b_q << 1;
		end
	end

	assign product = acc;

	step_bound: assert property (@(posedge clk) disable iff (reset) step <= gf_m)
		else $error("serial multiplier step counter overran");

endmodule

/* source/gf_inverter.sv */
module gf_inverter import gf_pkg::*; (
	input clk,
	input reset,
	input load,
	input gf_elem_t a,
	output gf_elem_t inverse,
	output logic finished
);

	gf_elem_t pow_q;
	gf_elem_t acc_q;
	gf_elem_t sq_in;
	gf_elem_t sq_out;
	gf_elem_t prod;
	gf_step_t step;
	logic running;

	// on load the squarer works on the fresh operand
	assign sq_in = load ? a : pow_q;

	gf_square_cube sq_i (
		.a(sq_in),
		.square(sq_out),
		.cube()
	);

	gf_parallel_mult mult_i (
		.a(acc_q),
		.b(pow_q),
		.product(prod)
	);

	// a^254 = a^2 * a^4 * ... * a^128, one factor per step
	always_ff @(posedge clk) begin
		if (reset) begin
			step <= '0;
			running <= 1'b0;
			finished <= 1'b0;
		end else begin
			finished <= 1'b0;
			if (load) begin
				step <= '0;
				running <= 1'b1;
			end else if (running) begin
				if (step == gf_m - 1) begin
					running <= 1'b0;
					finished <= 1'b1;
				end else begin
					step <= step + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			pow_q <= sq_out;
			acc_q <= gf_elem_t'(1);
		end else if (running && step != gf_m - 1) begin
			pow_q <= sq_out;
			acc_q <= prod;
		end
	end

	// zero input: pow_q is zero, so the first step clears acc_q
	assign inverse = acc_q;

	single_finish: assert property (@(posedge clk) disable iff (reset)
		finished |=> !finished)
		else $error("inverter finished lasted two cycles");

endmodule

/* source/gf_alpha_counter.sv */
module gf_alpha_counter import gf_pkg::*; (
	input clk,
	input reset,
	input load,
	input gf_elem_t exponent,
	output gf_elem_t power,
	output logic finished
);

	gf_elem_t count;

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
			finished <= 1'b0;
		end else begin
			finished <= 1'b0;
			if (load) begin
				count <= exponent;
				// alpha^0 needs no steps
				finished <= (exponent == '0);
			end else if (count != '0) begin
				count <= count - 1'b1;
				finished <= (count == gf_elem_t'(1));
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			power <= gf_elem_t'(1);
		end else if (count != '0) begin
			power <= gf_xtime(power);
		end
	end

endmodule

/* source/gf_alu.sv */
module gf_alu import gf_pkg::*; (
	input clk,
	input reset,
	input start,
	input gf_op_t op,
	input gf_elem_t a,
	input gf_elem_t b,
	output gf_elem_t result,
	output logic done,
	output logic busy
);

	gf_op_t op_q;
	gf_elem_t a_q;
	gf_elem_t b_q;
	logic comb_pend;

	logic accept;
	logic is_multi;
	logic load_serial;
	logic load_inv;
	logic load_alpha;

	gf_elem_t par_prod;
	gf_elem_t sq;
	gf_elem_t cb;
	gf_elem_t ser_prod;
	gf_elem_t inv;
	gf_elem_t alpha;
	logic ser_fin;
	logic inv_fin;
	logic alpha_fin;
	logic unit_fin;

	gf_elem_t comb_result;
	gf_elem_t unit_result;

	assign accept = start && !busy;
	assign is_multi = (op == op_mul_serial) || (op == op_inverse) || (op == op_alpha_pow);

	// multi-cycle units load straight from the inputs on the start edge
	assign load_serial = accept && (op == op_mul_serial);
	assign load_inv = accept && (op == op_inverse);
	assign load_alpha = accept && (op == op_alpha_pow);

	gf_parallel_mult par_i (
		.a(a_q),
		.b(b_q),
		.product(par_prod)
	);

	gf_square_cube sc_i (
		.a(a_q),
		.square(sq),
		.cube(cb)
	);

	gf_serial_mult ser_i (
		.clk(clk),
		.reset(reset),
		.load(load_serial),
		.a(a),
		.b(b),
		.product(ser_prod),
		.finished(ser_fin)
	);

	gf_inverter inv_i (
		.clk(clk),
		.reset(reset),
		.load(load_inv),
		.a(a),
		.inverse(inv),
		.finished(inv_fin)
	);

	gf_alpha_counter alpha_i (
		.clk(clk),
		.reset(reset),
		.load(load_alpha),
		.exponent(a),
		.power(alpha),
		.finished(alpha_fin)
	);

	assign unit_fin = ser_fin || inv_fin || alpha_fin;

	always_comb begin
		case (op_q)
			op_square: comb_result = sq;
			op_cube: comb_result = cb;
			default: comb_result = par_prod;
		endcase
	end

	always_comb begin
		case (op_q)
			op_inverse: unit_result = inv;
			op_alpha_pow: unit_result = alpha;
			default: unit_result = ser_prod;
		endcase
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			a_q <= a;
			b_q <= b;
		end
	end

	// a comb op and a unit completion never share an edge, busy blocks the start
	always_ff @(posedge clk) begin
		if (reset) begin
			op_q <= op_mul;
			comb_pend <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			result <= '0;
		end else begin
			done <= 1'b0;
			comb_pend <= accept && !is_multi;
			if (accept) begin
				op_q <= op;
			end
			if (accept && is_multi) begin
				busy <= 1'b1;
			end
			if (comb_pend) begin
				result <= comb_result;
				done <= 1'b1;
			end
			if (unit_fin) begin
				result <= unit_result;
				done <= 1'b1;
				busy <= 1'b0;
			end
		end
	end

	// back-to-back starts give one done cycle per accepted start
	done_pulse: assert property (@(posedge clk) disable iff (reset)
		(done && !$past(accept)) |=> !done)
		else $error("done held for two cycles");

	// busy is low with done unless a multi-cycle op was accepted on that edge
	busy_release: assert property (@(posedge clk) disable iff (reset)
		done |-> (!busy || $past(accept && is_multi)))
		else $error("busy still high with done");

	fin_source: assert property (@(posedge clk) disable iff (reset)
		unit_fin |-> (ser_fin && op_q == op_mul_serial)
			|| (inv_fin && op_q == op_inverse)
			|| (alpha_fin && op_q == op_alpha_pow))
		else $error("finished from a unit the op did not select");

endmodule

/* sim/gf_model.svh */
`ifndef GF_MODEL_SVH
`define GF_MODEL_SVH

// carry-less product to 15 bits, then fold the top terms back with x^8+x^4+x^3+x^2+1
function automatic gf_elem_t ref_mul(input gf_elem_t x, input gf_elem_t y);
	logic [14:0] prod;
	prod = '0;
	for (int i = 0; i < 8; i++) begin
		if (y[i]) begin
			prod = prod ^ (15'(x) << i);
		end
	end
	for (int k = 14; k >= 8; k--) begin
		if (prod[k]) begin
			prod = prod ^ (15'h11d << (k - 8));
		end
	end
	return prod[7:0];
endfunction

function automatic gf_elem_t ref_pow(input gf_elem_t x, input int e);
	gf_elem_t acc;
	acc = 8'h01;
	for (int i = 0; i < e; i++) begin
		acc = ref_mul(acc, x);
	end
	return acc;
endfunction

// multiplicative group has order 255
function automatic gf_elem_t ref_inv(input gf_elem_t x);
	return ref_pow(x, 254);
endfunction

function automatic gf_elem_t ref_alpha_pow(input int e);
	gf_elem_t p;
	p = 8'h01;
	for (int i = 0; i < e; i++) begin
		p = ref_mul(p, 8'h02);
	end
	return p;
endfunction

`endif

/* sim/gf_alu_tb.sv */
module gf_alu_tb import gf_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	`include "gf_model.svh"

	localparam int reset_cycles = 16;
	localparam int n_tests = 300;
	localparam int test_cycles = 260;
	localparam int cycle_limit = n_tests * test_cycles + reset_cycles;

	logic clk;
	logic reset;
	logic start;
	gf_op_t op;
	gf_elem_t a;
	gf_elem_t b;
	gf_elem_t result;
	logic done;
	logic busy;

	logic [31:0] lcg_state;
	int cycle_count;
	int value_errors;
	int other_errors;

	// one entry per accepted start, oldest first
	gf_elem_t exp_q[$];
	gf_elem_t arg_q[$];
	gf_op_t opcode_q[$];
	string name_q[$];
	int due_q[$];

	gf_alu gf_alu_i (
		.clk(clk),
		.reset(reset),
		.start(start),
		.op(op),
		.a(a),
		.b(b),
		.result(result),
		.done(done),
		.busy(busy)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic gf_elem_t rand_elem();
		lcg_state = lcg_next(lcg_state);
		return lcg_state[23:16];
	endfunction

	function automatic gf_elem_t expect_for(input gf_op_t o, input gf_elem_t x, input gf_elem_t y);
		gf_elem_t r;
		case (o)
			op_mul, op_mul_serial: r = ref_mul(x, y);
			op_square: r = ref_pow(x, 2);
			op_cube: r = ref_pow(x, 3);
			op_inverse: r = ref_inv(x);
			default: r = ref_alpha_pow(int'(x));
		endcase
		return r;
	endfunction

	// edges from the accepting edge to done
	function automatic int latency_for(input gf_op_t o, input gf_elem_t x);
		if (o == op_mul_serial || o == op_inverse) begin
			return gf_m + 1;
		end
		if (o == op_alpha_pow) begin
			return int'(x) + 1;
		end
		return 1;
	endfunction

	// called on a falling edge, start stays high until the caller drops it
	task automatic drive_start(input gf_op_t o, input gf_elem_t x, input gf_elem_t y,
		input string name);
		start = 1'b1;
		op = o;
		a = x;
		b = y;
		exp_q.push_back(expect_for(o, x, y));
		arg_q.push_back(x);
		opcode_q.push_back(o);
		name_q.push_back(name);
		due_q.push_back(cycle_count + 1 + latency_for(o, x));
	endtask

	task automatic issue(input gf_op_t o, input gf_elem_t x, input gf_elem_t y, input string name);
		@(negedge clk);
		drive_start(o, x, y, name);
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic wait_idle();
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
	endtask

	task automatic start_while_busy(input gf_op_t o);
		gf_elem_t x;
		gf_elem_t y;
		x = rand_elem();
		y = rand_elem();
		issue(o, x, y, "start_while_busy");
		if (busy !== 1'b1) begin
			$display("busy did not rise after an accepted %s", o.name());
			other_errors++;
		end
		repeat (3) @(negedge clk);
		start = 1'b1;
		op = op_mul;
		a = ~x;
		b = ~y;
		@(negedge clk);
		start = 1'b0;
		wait_idle();
		// a second done would find the queue empty
		repeat (2 * gf_m) @(negedge clk);
	endtask

	always @(negedge clk) begin : compare
		gf_elem_t expected;
		gf_elem_t arg;
		gf_elem_t product;
		gf_op_t kind;
		string name;
		int due;
		if (!reset && done) begin
			if (exp_q.size() == 0) begin
				$display("done pulsed at cycle %0d with no operation outstanding", cycle_count);
				other_errors++;
			end else begin
				expected = exp_q.pop_front();
				arg = arg_q.pop_front();
				kind = opcode_q.pop_front();
				name = name_q.pop_front();
				due = due_q.pop_front();
				if (kind == op_inverse && arg != 8'h00) begin
					// a * a^-1 must be one
					product = ref_mul(result, arg);
					if (product !== 8'h01) begin
						$display("[FAIL] %s a=%h: expected product 01, actual product %h",
							name, arg, product);
						value_errors++;
					end
				end else if (result !== expected) begin
					$display("[FAIL] %s a=%h: expected %h, actual %h", name, arg, expected, result);
					value_errors++;
				end
				if (cycle_count != due) begin
					$display("[FAIL] %s latency: expected done at cycle %0d, actual %0d",
						name, due, cycle_count);
					value_errors++;
				end
				if (busy !== 1'b0) begin
					$display("busy still high when %s finished", name);
					other_errors++;
				end
			end
		end
	end

	initial begin : watchdog
		while (cycle_count < cycle_limit) begin
			@(negedge clk);
		end
		$display("run stopped after %0d cycles with %0d operations outstanding",
			cycle_count, exp_q.size());
		$display("errors: %0d wrong values, %0d other failures", value_errors, other_errors + 1);
		$display("Simulation failed");
		$finish;
	end

	initial begin : stimulus
		gf_elem_t x;
		gf_elem_t y;
		logic [31:0] sel;
		gf_elem_t fixed_exp[4] = '{8'd0, 8'd1, 8'd8, 8'd255};
		reset = 1'b1;
		start = 1'b0;
		op = op_mul;
		a = '0;
		b = '0;
		lcg_state = 32'h5eca_3a6f;
		cycle_count = 0;
		value_errors = 0;
		other_errors = 0;
		repeat (reset_cycles) @(negedge clk);
		reset = 1'b0;

		repeat (2) @(negedge clk);
		if (done !== 1'b0 || busy !== 1'b0) begin
			$display("done or busy high after reset with no start");
			other_errors++;
		end
		if (result !== 8'h00) begin
			$display("[FAIL] reset_result: expected 00, actual %h", result);
			value_errors++;
		end

		for (int i = 0; i < 40; i++) begin
			x = rand_elem();
			y = rand_elem();
			issue(op_mul, x, y, "mul");
			issue(op_mul_serial, x, y, "mul_serial");
			wait_idle();
		end
		x = rand_elem();
		issue(op_mul, x, 8'h01, "mul_by_one");
		issue(op_mul_serial, x, 8'h01, "serial_by_one");
		wait_idle();
		issue(op_mul, x, 8'h00, "mul_by_zero");
		issue(op_mul_serial, x, 8'h00, "serial_by_zero");
		wait_idle();

		// one start on every cycle
		for (int i = 0; i < 40; i++) begin
			x = rand_elem();
			@(negedge clk);
			drive_start(op_square, x, 8'h00, "square");
			@(negedge clk);
			drive_start(op_cube, x, 8'h00, "cube");
		end
		@(negedge clk);
		start = 1'b0;
		wait_idle();

		for (int v = 0; v < 256; v++) begin
			issue(op_inverse, gf_elem_t'(v), 8'h00, "inverse");
			wait_idle();
		end

		for (int i = 0; i < 4; i++) begin
			issue(op_alpha_pow, fixed_exp[i], 8'h00, "alpha_pow_fixed");
			wait_idle();
		end
		for (int i = 0; i < 20; i++) begin
			issue(op_alpha_pow, rand_elem(), 8'h00, "alpha_pow");
			wait_idle();
		end

		start_while_busy(op_mul_serial);
		start_while_busy(op_inverse);

		// mixed opcodes
		for (int i = 0; i < 30; i++) begin
			sel = {24'b0, rand_elem()} % 32'd6;
			x = rand_elem();
			y = rand_elem();
			issue(gf_op_t'(sel[2:0]), x, y, "mixed");
			wait_idle();
		end

		repeat (4) @(negedge clk);
		if (exp_q.size() != 0) begin
			$display("%0d operations still outstanding at the end", exp_q.size());
			other_errors++;
		end
		$display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* src.f */
+incdir+sim
source/gf_pkg.sv
source/gf_parallel_mult.sv
source/gf_square_cube.sv
source/gf_serial_mult.sv
source/gf_inverter.sv
source/gf_alpha_counter.sv
source/gf_alu.sv
sim/gf_alu_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --top-module gf_alu_tb -f src.f -o gf_alu_sim \
	> build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "verilator build failed"
	exit 1
fi

./obj_dir/gf_alu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Simulation completed successfully" sim.log; then
	exit 0
fi
exit 1
